// File: dadda_mult.f
hw/dadda_pkg.sv
hw/mult_ctrl.sv
hw/pp_reduce.sv
hw/product_merge.sv
hw/dadda_mult.sv
testbench/dadda_mult_asserts.sv
testbench/tb_dadda_mult.sv

// File: hw/dadda_mult.sv
`timescale 1ns/100ps

module dadda_mult #(
  parameter int WIDTH = dadda_pkg::OPERAND_W,
  parameter int SLICE = dadda_pkg::SLICE_W
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 req,
  input  dadda_pkg::operands_t operands,
  output logic                 ack,
  output dadda_pkg::product_t  product
);

  dadda_pkg::operands_t opnd_q;
  dadda_pkg::csa_rows_t rows_lo;
  dadda_pkg::csa_rows_t rows_hi;
  logic                 red_en;
  logic                 mrg_en;

  // handshake and stage sequencing
  mult_ctrl u_ctrl (
    .clk      (clk),
    .rst_n    (rst_n),
    .req      (req),
    .operands (operands),
    .opnd_q   (opnd_q),
    .red_en   (red_en),
    .mrg_en   (mrg_en),
    .ack      (ack)
  );

  ////////////////////////////////
  // reduction slices
  ////////////////////////////////

  // low byte of B
  pp_reduce #(
    .WIDTH (WIDTH),
    .SLICE (SLICE)
  ) u_red_lo (
    .clk     (clk),
    .a       (opnd_q.a),
    .b_slice (opnd_q.b[SLICE-1:0]),
    .en      (red_en),
    .rows    (rows_lo)
  );

  // high byte of B, weighted by 2^SLICE in the merge
  pp_reduce #(
    .WIDTH (WIDTH),
    .SLICE (SLICE)
  ) u_red_hi (
    .clk     (clk),
    .a       (opnd_q.a),
    .b_slice (opnd_q.b[WIDTH-1:SLICE]),
    .en      (red_en),
    .rows    (rows_hi)
  );

  product_merge u_merge (
    .clk     (clk),
    .rst_n   (rst_n),
    .rows_lo (rows_lo),
    .rows_hi (rows_hi),
    .en      (mrg_en),
    .product (product)
  );

endmodule

// File: hw/dadda_pkg.sv
package dadda_pkg;

  ////////////////////////////////
  // widths
  ////////////////////////////////

  parameter int OPERAND_W = 16;
  // B is split into two slices
  parameter int SLICE_W   = OPERAND_W / 2;
  parameter int PRODUCT_W = 2 * OPERAND_W;

  ////////////////////////////////
  // data types
  ////////////////////////////////

  typedef struct packed {
    logic [OPERAND_W-1:0] a;
    logic [OPERAND_W-1:0] b;
  } operands_t;

  typedef logic [PRODUCT_W-1:0] product_t;

  // carry-save result of one slice, A width plus slice width
  typedef struct packed {
    logic [OPERAND_W+SLICE_W-1:0] sum_row;
    logic [OPERAND_W+SLICE_W-1:0] carry_row;
  } csa_rows_t;

  ////////////////////////////////
  // handshake FSM
  ////////////////////////////////

  typedef enum logic [1:0] {
    st_idle,
    st_reduce,
    st_merge,
    st_hold
  } ctrl_state_t;

endpackage

// File: hw/mult_ctrl.sv
`timescale 1ns/100ps

module mult_ctrl (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 req,
  input  dadda_pkg::operands_t operands,
  output dadda_pkg::operands_t opnd_q,
  output logic                 red_en,
  output logic                 mrg_en,
  output logic                 ack
);

  dadda_pkg::ctrl_state_t state;
  logic                   cap_en;

  // accept a new request only from idle
  assign cap_en = (state == dadda_pkg::st_idle) && req;

  ////////////////////////////////
  // operand capture
  ////////////////////////////////

  // held through st_hold, later operand changes are ignored
  always_ff @(posedge clk) begin
    if (cap_en) begin
      opnd_q <= operands;
    end
  end

  ////////////////////////////////
  // four-phase FSM
  ////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state  <= dadda_pkg::st_idle;
      red_en <= 1'b0;
      mrg_en <= 1'b0;
      ack    <= 1'b0;
    end else begin
      // enables are single-cycle pulses
      red_en <= 1'b0;
      mrg_en <= 1'b0;
      case (state)
        dadda_pkg::st_idle: begin
          if (cap_en) begin
            state  <= dadda_pkg::st_reduce;
            red_en <= 1'b1;
          end
        end
        dadda_pkg::st_reduce: begin
          // slices load their rows on this edge
          state  <= dadda_pkg::st_merge;
          mrg_en <= 1'b1;
        end
        dadda_pkg::st_merge: begin
          // product lands together with ack
          state <= dadda_pkg::st_hold;
          ack   <= 1'b1;
        end
        dadda_pkg::st_hold: begin
          // wait for the requester to drop req
          if (!req) begin
            state <= dadda_pkg::st_idle;
            ack   <= 1'b0;
          end
        end
        default: begin
          state <= dadda_pkg::st_idle;
          ack   <= 1'b0;
        end
      endcase
    end
  end

endmodule

// File: hw/pp_reduce.sv
`timescale 1ns/100ps

module pp_reduce #(
  parameter int WIDTH = 16,
  parameter int SLICE = 8
) (
  input  logic                 clk,
  input  logic [WIDTH-1:0]     a,
  input  logic [SLICE-1:0]     b_slice,
  input  logic                 en,
  output dadda_pkg::csa_rows_t rows
);

  localparam int COLS = WIDTH + SLICE;
  // tallest column of the AND array
  localparam int MAXH = SLICE;

  // dadda sequence 2, 3, 4, 6, 9 ...
  function automatic int dadda_d(input int k);
    int d;
    int i;
    d = 2;
    for (i = 1; i < k; i++) begin
      d = (d * 3) / 2;
    end
    return d;
  endfunction

  function automatic int num_stages();
    int k;
    k = 0;
    while (dadda_d(k + 1) < MAXH) begin
      k++;
    end
    return k;
  endfunction

  localparam int NST = num_stages();

  // what: 0 height before stage s, 1 full adders, 2 half adders
  function automatic int col_plan(input int s, input int c, input int what);
    int ht [0:COLS-1];
    int fa [0:COLS-1];
    int ha [0:COLS-1];
    int st;
    int col;
    int i;
    int ex;
    int prev;
    if (c < 0 || c >= COLS) begin
      return 0;
    end
    for (col = 0; col < COLS; col++) begin
      ht[col] = 0;
      for (i = 0; i < SLICE; i++) begin
        if (col - i >= 0 && col - i < WIDTH) begin
          ht[col]++;
        end
      end
    end
    for (st = 0; st <= s; st++) begin
      prev = 0;
      for (col = 0; col < COLS; col++) begin
        // carries arriving from the column below count against the target
        ex = ht[col] + prev - ((st < NST) ? dadda_d(NST - st) : COLS);
        fa[col] = (ex > 0) ? ex / 2 : 0;
        ha[col] = (ex > 0) ? ex % 2 : 0;
        prev = fa[col] + ha[col];
      end
      if (st < s) begin
        prev = 0;
        for (col = 0; col < COLS; col++) begin
          ht[col] = ht[col] - 2 * fa[col] - ha[col] + prev;
          prev = fa[col] + ha[col];
        end
      end
    end
    return (what == 0) ? ht[c] : ((what == 1) ? fa[c] : ha[c]);
  endfunction

  // column bits per stage, short columns padded with zeros
  wire [MAXH-1:0] lvl   [0:NST][0:COLS-1];
  wire [MAXH-1:0] fa_co [0:NST-1][0:COLS-1];
  wire [MAXH-1:0] ha_co [0:NST-1][0:COLS-1];

  logic [COLS-1:0] sum_d;
  logic [COLS-1:0] carry_d;

  genvar s, c, k;

  ////////////////////////////////
  // partial products
  ////////////////////////////////

  for (c = 0; c < COLS; c++) begin : g_pp
    localparam int ILO = (c >= WIDTH) ? c - WIDTH + 1 : 0;
    localparam int H0  = col_plan(0, c, 0);
    for (k = 0; k < MAXH; k++) begin : g_bit
      if (k < H0) begin : g_and
        assign lvl[0][c][k] = a[c - ILO - k] & b_slice[ILO + k];
      end else begin : g_zero
        assign lvl[0][c][k] = 1'b0;
      end
    end
  end

  ////////////////////////////////
  // dadda stages
  ////////////////////////////////

  for (s = 0; s < NST; s++) begin : g_stage
    for (c = 0; c < COLS; c++) begin : g_col
      localparam int H     = col_plan(s, c, 0);
      localparam int NFA   = col_plan(s, c, 1);
      localparam int NHA   = col_plan(s, c, 2);
      localparam int FA_IN = col_plan(s, c - 1, 1);
      localparam int HA_IN = col_plan(s, c - 1, 2);
      localparam int USED  = 3 * NFA + 2 * NHA;
      // new column order: fa sums, ha sums, untouched bits, carries in
      localparam int BASE  = NFA + NHA + (H - USED);
      for (k = 0; k < MAXH; k++) begin : g_bit
        if (k < NFA) begin : g_fa
          logic [2:0] fin;
          assign fin              = lvl[s][c][3*k +: 3];
          assign lvl[s+1][c][k]   = ^fin;
          assign fa_co[s][c][k]   = (fin[0] & fin[1]) | (fin[2] & (fin[0] ^ fin[1]));
        end else if (k < NFA + NHA) begin : g_ha
          logic [1:0] hin;
          assign hin                  = lvl[s][c][3*NFA + 2*(k-NFA) +: 2];
          assign lvl[s+1][c][k]       = ^hin;
          assign ha_co[s][c][k - NFA] = &hin;
        end else if (k < BASE) begin : g_pass
          assign lvl[s+1][c][k] = lvl[s][c][USED + k - NFA - NHA];
        end else if (k < BASE + FA_IN) begin : g_cfa
          assign lvl[s+1][c][k] = fa_co[s][c-1][k - BASE];
        end else if (k < BASE + FA_IN + HA_IN) begin : g_cha
          assign lvl[s+1][c][k] = ha_co[s][c-1][k - BASE - FA_IN];
        end else begin : g_zero
          assign lvl[s+1][c][k] = 1'b0;
        end
        if (k >= NFA) begin : g_fa_none
          assign fa_co[s][c][k] = 1'b0;
        end
        if (k >= NHA) begin : g_ha_none
          assign ha_co[s][c][k] = 1'b0;
        end
      end
    end
  end

  // at most two bits left per column
  for (c = 0; c < COLS; c++) begin : g_rows
    assign sum_d[c]   = lvl[NST][c][0];
    assign carry_d[c] = lvl[NST][c][1];
  end

  always_ff @(posedge clk) begin
    if (en) begin
      rows.sum_row   <= sum_d;
      rows.carry_row <= carry_d;
    end
  end

endmodule

// File: hw/product_merge.sv
`timescale 1ns/100ps

module product_merge (
  input  logic                 clk,
  input  logic                 rst_n,
  input  dadda_pkg::csa_rows_t rows_lo,
  input  dadda_pkg::csa_rows_t rows_hi,
  input  logic                 en,
  output dadda_pkg::product_t  product
);

  localparam int PW  = dadda_pkg::PRODUCT_W;
  localparam int SW  = dadda_pkg::SLICE_W;
  localparam int PAD = PW - (dadda_pkg::OPERAND_W + SW);

  ////////////////////////////////
  // alignment
  ////////////////////////////////

  logic [PW-1:0] r0, r1, r2, r3;

  assign r0 = {{PAD{1'b0}}, rows_lo.sum_row};
  assign r1 = {{PAD{1'b0}}, rows_lo.carry_row};
  // high slice sits SLICE_W columns up
  assign r2 = {rows_hi.sum_row, {SW{1'b0}}};
  assign r3 = {rows_hi.carry_row, {SW{1'b0}}};

  ////////////////////////////////
  // 4:2 compressor layer
  ////////////////////////////////

  logic [PW-1:0] t, x, y, cx_in;
  logic [PW-2:0] cx, cy;

  // first full adder per column
  assign t  = r0 ^ r1 ^ r2;
  assign cx = (r0[PW-2:0] & r1[PW-2:0]) | (r2[PW-2:0] & (r0[PW-2:0] ^ r1[PW-2:0]));

  // second full adder takes the lateral carry
  assign cx_in = {cx, 1'b0};
  assign x     = t ^ r3 ^ cx_in;
  assign cy    = (t[PW-2:0] & r3[PW-2:0]) | (cx_in[PW-2:0] & (t[PW-2:0] ^ r3[PW-2:0]));
  assign y     = {cy, 1'b0};

  ////////////////////////////////
  // ripple-carry resolution
  ////////////////////////////////

  logic [PW-1:0] rc;
  logic [PW-1:0] sum_d;

  assign rc[0] = 1'b0;

  genvar i;
  for (i = 0; i < PW; i++) begin : g_rca
    assign sum_d[i] = x[i] ^ y[i] ^ rc[i];
    // carry out of the top bit is always zero
    if (i < PW - 1) begin : g_carry
      assign rc[i+1] = (x[i] & y[i]) | (rc[i] & (x[i] ^ y[i]));
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      product <= '0;
    end else if (en) begin
      product <= sum_d;
    end
  end

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the testbench with Verilator, result taken from the log
cd "$(dirname "$0")" || exit 1
LOG=sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_dadda_mult \
  -f dadda_mult.f --Mdir obj_dir -o tb_dadda_mult > "$LOG" 2>&1 \
  && ./obj_dir/tb_dadda_mult +verilator+error+limit+100 >> "$LOG" 2>&1 \
  || { echo "build or simulation did not complete"; tail -n 20 "$LOG"; exit 1; }
cat "$LOG"
grep -q "TB FAILED" "$LOG" && exit 1 || exit 0

// File: testbench/dadda_mult_asserts.sv
`timescale 1ns/100ps

module dadda_mult_asserts (
  input logic                clk,
  input logic                rst_n,
  input logic                req,
  input logic                ack,
  input logic                red_en,
  input dadda_pkg::product_t product
);

  int unsigned err_count = 0;

  ////////////////////////////////
  // handshake
  ////////////////////////////////

  // ack only while req is up, or one edge after it drops
  a_ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
    ack |-> (req || $past(req)))
    else begin
      $error("ack high without a request");
      err_count++;
    end

  // three edges from req sampled in idle to ack seen high
  a_ack_latency: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(ack) |-> ($past(red_en, 2) && $past(req, 3)))
    else begin
      $error("ack rose at the wrong edge");
      err_count++;
    end

  a_product_stable: assert property (@(posedge clk) disable iff (!rst_n)
    (ack && $past(ack)) |-> $stable(product))
    else begin
      $error("product changed while ack was high");
      err_count++;
    end

  a_ack_after_reset: assert property (@(posedge clk)
    $past(!rst_n) |-> !ack)
    else begin
      $error("ack high after reset");
      err_count++;
    end

endmodule

bind dadda_mult dadda_mult_asserts u_asserts (
  .clk     (clk),
  .rst_n   (rst_n),
  .req     (req),
  .ack     (ack),
  .red_en  (red_en),
  .product (product)
);

// File: testbench/tb_dadda_mult.sv
`timescale 1ns/100ps

module tb_dadda_mult;

  localparam int CLK_PERIOD = 100;
  localparam int RST_CYCLES = 16;
  localparam int N_RANDOM   = 500;
  localparam int N_TESTS    = N_RANDOM + 10;
  localparam int TIMEOUT_NS = (N_TESTS * 20 + RST_CYCLES) * CLK_PERIOD;

  logic                 clk = 1'b0;
  logic                 rst_n;
  logic                 req;
  dadda_pkg::operands_t operands;
  logic                 ack;
  dadda_pkg::product_t  product;

  dadda_pkg::product_t exp_q[$];
  string               name_q[$];
  dadda_pkg::product_t cur_exp;
  string               cur_name;
  logic                ack_prev = 1'b0;
  logic [31:0]         rng = 32'd64946;
  int                  errors = 0;
  int                  n_pass = 0;
  int                  n_fail = 0;

  dadda_mult dadda_mult_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .req      (req),
    .operands (operands),
    .ack      (ack),
    .product  (product)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // plain 32-bit multiply of the zero-extended operands
  function automatic dadda_pkg::product_t ref_product(
    input logic [dadda_pkg::OPERAND_W-1:0] a,
    input logic [dadda_pkg::OPERAND_W-1:0] b
  );
    logic [dadda_pkg::PRODUCT_W-1:0] wa;
    logic [dadda_pkg::PRODUCT_W-1:0] wb;
    wa = {{dadda_pkg::OPERAND_W{1'b0}}, a};
    wb = {{dadda_pkg::OPERAND_W{1'b0}}, b};
    return wa * wb;
  endfunction

  ////////////////////////////////
  // compare tasks
  ////////////////////////////////

  task automatic check_product(input string name, input dadda_pkg::product_t exp,
                               input dadda_pkg::product_t act);
    if (act !== exp) begin
      $display("Fail %s expected %h actual %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_ack(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("Fail %s expected %b actual %b", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_state(input string name, input dadda_pkg::ctrl_state_t exp,
                             input dadda_pkg::ctrl_state_t act);
    if (act !== exp) begin
      $display("Fail %s expected %s actual %s", name, exp.name(), act.name());
      errors++;
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    if (errors == errs_before) begin
      n_pass++;
      $display("ok   %s", name);
    end else begin
      n_fail++;
      $display("bad  %s", name);
    end
  endtask

  // one four-phase transfer, req held for extra cycles when hold is set
  task automatic do_request(input string name, input logic [15:0] a, input logic [15:0] b,
                            input int hold);
    int errs_before;
    int i;
    errs_before = errors;
    exp_q.push_back(ref_product(a, b));
    name_q.push_back(name);
    operands.a = a;
    operands.b = b;
    req = 1'b1;
    for (i = 1; i <= 3; i++) begin
      @(negedge clk);
      check_ack({name, " ack latency"}, i == 3, ack);
    end
    while (!ack) @(negedge clk);
    for (i = 0; i < hold; i++) begin
      rng = xorshift(rng);
      operands = rng;
      @(negedge clk);
      check_ack({name, " ack held"}, 1'b1, ack);
    end
    req = 1'b0;
    @(negedge clk);
    check_ack({name, " ack release"}, 1'b0, ack);
    report_test(name, errs_before);
  endtask

  ////////////////////////////////
  // compare process
  ////////////////////////////////

  always @(negedge clk) begin
    if (rst_n) begin
      if (ack && !ack_prev) begin
        if (exp_q.size() == 0) begin
          $display("ack rose with no request outstanding");
          errors++;
        end else begin
          cur_exp = exp_q.pop_front();
          cur_name = name_q.pop_front();
          check_product(cur_name, cur_exp, product);
        end
      end else if (ack) begin
        check_product({cur_name, " hold"}, cur_exp, product);
      end
    end
    ack_prev = ack;
  end

  initial begin
    int i;
    int errs_before;
    rst_n = 1'b0;
    req = 1'b0;
    operands = '0;
    repeat (RST_CYCLES) @(negedge clk);
    rst_n = 1'b1;
    errs_before = errors;
    check_ack("reset ack", 1'b0, ack);
    check_product("reset product", '0, product);
    check_state("reset state", dadda_pkg::st_idle, dadda_mult_i.u_ctrl.state);
    report_test("reset", errs_before);

    do_request("zero times x", 16'h0000, 16'h1234, 0);
    do_request("x times zero", 16'hBEEF, 16'h0000, 0);
    do_request("one times x", 16'h0001, 16'hBEEF, 0);
    do_request("ffff times ffff", 16'hFFFF, 16'hFFFF, 0);
    do_request("8000 times 0002", 16'h8000, 16'h0002, 0);
    // terms only from the high byte of b
    do_request("high slice 0100", 16'h1234, 16'h0100, 0);
    do_request("high slice ff00", 16'hFFFF, 16'hFF00, 0);
    do_request("high slice 8000", 16'hABCD, 16'h8000, 0);
    for (i = 0; i < N_RANDOM; i++) begin
      rng = xorshift(rng);
      do_request($sformatf("random %0d", i), rng[15:0], rng[31:16], 0);
    end
    do_request("hold with operand change", 16'hC3A5, 16'h7E19, 10);

    $display("tests passed %0d failed %0d", n_pass, n_fail);
    if (dadda_mult_i.u_asserts.err_count != 0) begin
      $display("%0d assertion failures were reported", dadda_mult_i.u_asserts.err_count);
    end
    if (n_fail == 0 && errors == 0 && dadda_mult_i.u_asserts.err_count == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

  // watchdog
  initial begin
    #(TIMEOUT_NS);
    $display("timeout, the run did not finish within %0d ns", TIMEOUT_NS);
    $display("TB FAILED");
    $finish;
  end

endmodule
